// ==== Makefile ====
# Verilator build and run of the blur testbench
# any variable can be overridden, e.g. make run LOG=other.log

SIM       ?= verilator
TOP       ?= blur_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

# sources come from the file list, include directories left out
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== blur_pkg.sv ====
// shared pixel, accumulator and state types plus kernel constants, imported by the blur RTL and testbench
package blur_pkg;

    // one grayscale sample
    typedef logic [7:0] pixel_t;

    // engine control states
    // prologue fills the line buffer, filter computes one sum, emit writes it out
    typedef enum logic [1:0] {
        state_prologue = 2'd0,
        state_filter   = 2'd1,
        state_emit     = 2'd2
    } blur_state_t;

    // weighted sum width
    // worst case 255 * 159 = 40545, fits in 16 bits
    localparam int acc_width = 16;

    typedef logic [acc_width-1:0] acc_t;

    // window edge length
    localparam int kernel_size = 5;

    // fixed gaussian weights, symmetric in both axes
    // row index is the line offset, column index the pixel offset
    localparam logic [3:0] kernel_weight [kernel_size][kernel_size] = '{
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd5, 4'd12, 4'd15, 4'd12, 4'd5},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2}
    };

    // sum of all weights
    // same divisor at the frame border, so edge outputs come out darker
    localparam int kernel_norm = 159;

    // saturation bound of an output pixel
    localparam int pixel_max = 255;

endpackage

// ==== blur_tb.sv ====
// self-checking testbench for blur_top, runs a table of test images through the DUT and checks each pixel
`timescale 1ns/1ps

module blur_tb
    import blur_pkg::*;
();

    localparam int width        = 8;
    localparam int height       = 6;
    localparam int fifo_depth   = 16;
    localparam int frame_pixels = width * height;
    localparam int max_frames   = 3;
    localparam int n_tests      = 7;

    // test image kinds
    typedef enum logic [2:0] {
        pat_zeros,
        pat_flat,
        pat_impulse,
        pat_gradient,
        pat_random
    } pattern_t;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;

    // test table, one row per entry
    string    test_name    [n_tests];
    pattern_t test_pattern [n_tests];
    logic     test_stall   [n_tests];
    int       test_frames  [n_tests];

    // frames of the running test, back to back
    pixel_t   in_pix  [max_frames * frame_pixels];
    pixel_t   exp_pix [max_frames * frame_pixels];
    string    cur_name;
    logic     cur_stall;
    int       cur_total;
    logic     full_seen;

    logic [31:0] lfsr_state;
    int          cycles;
    int          cycle_limit;

    blur_top #(
        .width      (width),
        .height     (height),
        .fifo_depth (fifo_depth)
    ) dut0 (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // print the failure, then stop the run
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // watchdog on total cycles
    initial begin
        cycles = 0;
        forever begin
            @(posedge clock);
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
            end
        end
    end

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // n bits, one step each
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    task automatic check_pixel(input string name, input int idx,
                               input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s pixel %0d: expected %0d, actual %0d",
                                name, idx, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s %s: expected %0b, actual %0b",
                                name, what, expected, actual));
        end
    endtask

    task automatic set_entry(input int i, input string name, input pattern_t pat,
                             input logic stall, input int frames);
        test_name[i]    = name;
        test_pattern[i] = pat;
        test_stall[i]   = stall;
        test_frames[i]  = frames;
    endtask

    // reference blur, taps outside the frame dropped, divisor always 159
    function automatic pixel_t blur_ref(input int base, input int r, input int c);
        int sum;
        int q;
        sum = 0;
        for (int dr = -2; dr <= 2; dr++) begin
            for (int dc = -2; dc <= 2; dc++) begin
                if (r + dr >= 0 && r + dr < height && c + dc >= 0 && c + dc < width) begin
                    sum += int'(in_pix[base + (r + dr) * width + c + dc])
                         * int'(kernel_weight[dr + 2][dc + 2]);
                end
            end
        end
        q = sum / kernel_norm;
        if (q > pixel_max) begin
            q = pixel_max;
        end
        return pixel_t'(q);
    endfunction

    // fill input frames, then the expected frames from the model
    task automatic build_frames(input pattern_t pat, input int frames);
        int base;
        for (int f = 0; f < frames; f++) begin
            base = f * frame_pixels;
            for (int r = 0; r < height; r++) begin
                for (int c = 0; c < width; c++) begin
                    case (pat)
                        pat_zeros:    in_pix[base + r * width + c] = 8'd0;
                        pat_flat:     in_pix[base + r * width + c] = 8'd255;
                        // impulse of 159 so each neighbour equals its weight
                        pat_impulse:  in_pix[base + r * width + c] =
                                          (r == 2 && c == 3) ? 8'd159 : 8'd0;
                        pat_gradient: in_pix[base + r * width + c] =
                                          pixel_t'(c * 255 / (width - 1));
                        default:      in_pix[base + r * width + c] = pixel_t'(random_bits(8));
                    endcase
                end
            end
            for (int r = 0; r < height; r++) begin
                for (int c = 0; c < width; c++) begin
                    exp_pix[base + r * width + c] = blur_ref(base, r, c);
                end
            end
        end
    endtask

    // push whenever the input FIFO has room
    task automatic feed_pixels();
        int idx;
        idx = 0;
        while (idx < cur_total) begin
            if (in_full) begin
                full_seen = 1'b1;
                in_wr_en  = 1'b0;
            end else begin
                in_wr_en = 1'b1;
                in_din   = in_pix[idx];
                idx++;
            end
            @(posedge clock);
            #1;
        end
        in_wr_en = 1'b0;
    endtask

    // pop and compare in raster order
    task automatic drain_pixels();
        int   idx;
        logic take;
        idx = 0;
        while (idx < cur_total) begin
            take = !out_empty;
            if (cur_stall) begin
                // read on about one cycle in four
                if (random_bits(2) != 3) begin
                    take = 1'b0;
                end
            end
            out_rd_en = take;
            if (take) begin
                check_pixel(cur_name, idx, exp_pix[idx], out_dout);
                idx++;
            end
            @(posedge clock);
            #1;
        end
        out_rd_en = 1'b0;
    endtask

    initial begin
        int total_frames;
        reset      = 1'b1;
        in_wr_en   = 1'b0;
        in_din     = '0;
        out_rd_en  = 1'b0;
        full_seen  = 1'b0;
        lfsr_state = 32'h719d_003a;
        set_entry(0, "zeros", pat_zeros, 1'b0, 1);
        set_entry(1, "flat_255", pat_flat, 1'b0, 1);
        set_entry(2, "impulse", pat_impulse, 1'b0, 1);
        set_entry(3, "gradient", pat_gradient, 1'b0, 1);
        set_entry(4, "random", pat_random, 1'b0, 1);
        // one frame is too short to back up both FIFOs
        set_entry(5, "random_stall", pat_random, 1'b1, 3);
        set_entry(6, "back_to_back", pat_random, 1'b0, 3);
        total_frames = 0;
        for (int i = 0; i < n_tests; i++) begin
            total_frames += test_frames[i];
        end
        cycle_limit = total_frames * frame_pixels * 8 + 500;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            cur_name  = test_name[t];
            cur_stall = test_stall[t];
            cur_total = test_frames[t] * frame_pixels;
            full_seen = 1'b0;
            build_frames(test_pattern[t], test_frames[t]);
            fork
                feed_pixels();
                drain_pixels();
            join
            // nothing extra may follow the frame, and the input side drained
            check_flag(cur_name, "out_empty after frame", 1'b1, out_empty);
            check_flag(cur_name, "in_full after frame", 1'b0, in_full);
            if (cur_stall) begin
                check_flag(cur_name, "in_full seen during stalls", 1'b1, full_seen);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== blur_top.sv ====
// top level of the blur pipeline, input FIFO into the engine into the output FIFO
`timescale 1ns/1ps

module blur_top
    import blur_pkg::*;
#(
    parameter int width      = 64,
    parameter int height     = 48,
    parameter int fifo_depth = 16
) (
    input  logic   clock,
    input  logic   reset,
    // pixel source
    input  logic   in_wr_en,
    input  pixel_t in_din,
    output logic   in_full,
    // result sink, out_dout valid while out_empty is low
    input  logic   out_rd_en,
    output pixel_t out_dout,
    output logic   out_empty
);

    // input FIFO to engine
    logic   fifo_rd_en;
    logic   fifo_empty;
    pixel_t fifo_dout;

    // engine to output FIFO
    logic   blur_wr_en;
    logic   blur_full;
    pixel_t blur_din;

    // raster pixels in
    sync_fifo #(
        .fifo_depth (fifo_depth)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (fifo_rd_en),
        .empty (fifo_empty),
        .dout  (fifo_dout)
    );

    // 5x5 filter, stalls both ways through the FIFO flags
    gaussian_blur #(
        .width  (width),
        .height (height)
    ) blur0 (
        .clock      (clock),
        .reset      (reset),
        .fifo_rd_en (fifo_rd_en),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .blur_wr_en (blur_wr_en),
        .blur_full  (blur_full),
        .blur_din   (blur_din)
    );

    // blurred pixels out, same raster order
    sync_fifo #(
        .fifo_depth (fifo_depth)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (blur_wr_en),
        .din   (blur_din),
        .full  (blur_full),
        .rd_en (out_rd_en),
        .empty (out_empty),
        .dout  (out_dout)
    );

endmodule

// ==== files.f ====
blur_pkg.sv
sync_fifo.sv
gaussian_blur.sv
blur_top.sv
blur_tb.sv

// ==== gaussian_blur.sv ====
// streaming 5x5 gaussian blur engine, reads raster pixels from one FIFO and writes blurred pixels to another
`timescale 1ns/1ps

module gaussian_blur
    import blur_pkg::*;
#(
    parameter int width  = 64,
    parameter int height = 48
) (
    input  logic   clock,
    input  logic   reset,
    // input FIFO, first-word-fall-through
    output logic   fifo_rd_en,
    input  logic   fifo_empty,
    input  pixel_t fifo_dout,
    // output FIFO
    output logic   blur_wr_en,
    input  logic   blur_full,
    output pixel_t blur_din
);

    // four full lines plus five pixels cover the 5x5 window
    localparam int shift_len    = 4 * width + 5;
    localparam int frame_pixels = width * height;
    // pixels needed before the first centre sits at index 2*width+2
    localparam int prologue_len = 2 * width + 3;
    // last centre index that still has a real pixel to pull in
    localparam int last_fill    = frame_pixels - 1 - prologue_len;
    localparam int col_bits     = $clog2(width);
    localparam int row_bits     = $clog2(height);
    localparam int cnt_bits     = $clog2(prologue_len + 1);

    blur_state_t           state;
    blur_state_t           next_state;
    logic [cnt_bits-1:0]   fill_count;
    logic [cnt_bits-1:0]   fill_count_next;
    logic [col_bits-1:0]   col;
    logic [col_bits-1:0]   col_next;
    logic [row_bits-1:0]   row;
    logic [row_bits-1:0]   row_next;

    // line buffer, index 0 holds the oldest pixel
    pixel_t                shift_reg [shift_len];
    logic                  shift_en;
    pixel_t                shift_in;

    // window masks and sums
    logic [kernel_size-1:0] row_ok;
    logic [kernel_size-1:0] col_ok;
    acc_t                  col_sum [kernel_size];
    acc_t                  window_sum;
    acc_t                  sum_reg;
    logic                  sum_load;
    acc_t                  quotient;

    // frame position of the window centre
    int                    centre_idx;
    logic                  tail;
    logic                  at_frame_end;

    assign centre_idx = int'(row) * width + int'(col);
    // no more input for this frame, pad with zeros
    assign tail = (centre_idx > last_fill);
    // counters wrap to zero right after the last centre is filtered
    assign at_frame_end = (row == '0) && (col == '0);

    // which window lines and columns land inside the frame
    always_comb begin
        for (int k = 0; k < kernel_size; k++) begin
            row_ok[k] = (int'(row) + k - 2 >= 0) && (int'(row) + k - 2 < height);
            col_ok[k] = (int'(col) + k - 2 >= 0) && (int'(col) + k - 2 < width);
        end
    end

    // five column partial sums side by side
    // masked taps are skipped, so stale or padded data never contributes
    always_comb begin
        for (int c = 0; c < kernel_size; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < kernel_size; r++) begin
                if (row_ok[r] && col_ok[c]) begin
                    col_sum[c] = col_sum[c]
                               + acc_t'(shift_reg[r * width + c]) * acc_t'(kernel_weight[r][c]);
                end
            end
        end
    end

    // add up the columns
    always_comb begin
        window_sum = '0;
        for (int c = 0; c < kernel_size; c++) begin
            window_sum = window_sum + col_sum[c];
        end
    end

    // control FSM and handshakes
    always_comb begin
        next_state      = state;
        fill_count_next = fill_count;
        col_next        = col;
        row_next        = row;
        fifo_rd_en      = 1'b0;
        blur_wr_en      = 1'b0;
        shift_en        = 1'b0;
        shift_in        = fifo_dout;
        sum_load        = 1'b0;
        case (state)
            state_prologue: begin
                // fill the buffer until the first centre is in place
                if (!fifo_empty) begin
                    fifo_rd_en      = 1'b1;
                    shift_en        = 1'b1;
                    fill_count_next = fill_count + 1'b1;
                    if (fill_count == cnt_bits'(prologue_len - 1)) begin
                        next_state = state_filter;
                    end
                end
            end
            state_filter: begin
                // one step per output, either a fresh pixel or a zero pad
                if (tail || !fifo_empty) begin
                    fifo_rd_en = !tail;
                    shift_en   = 1'b1;
                    sum_load   = 1'b1;
                    if (tail) begin
                        shift_in = '0;
                    end
                    // raster advance, wrapping to the top after the last pixel
                    if (col == col_bits'(width - 1)) begin
                        col_next = '0;
                        if (row == row_bits'(height - 1)) begin
                            row_next = '0;
                        end else begin
                            row_next = row + 1'b1;
                        end
                    end else begin
                        col_next = col + 1'b1;
                    end
                    next_state = state_emit;
                end
            end
            state_emit: begin
                // hold here while the output FIFO is full
                if (!blur_full) begin
                    blur_wr_en = 1'b1;
                    next_state = state_filter;
                    if (at_frame_end) begin
                        next_state      = state_prologue;
                        fill_count_next = '0;
                    end
                end
            end
            default: begin
                next_state = state_prologue;
            end
        endcase
    end

    // control registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= state_prologue;
            fill_count <= '0;
            col        <= '0;
            row        <= '0;
        end else begin
            state      <= next_state;
            fill_count <= fill_count_next;
            col        <= col_next;
            row        <= row_next;
        end
    end

    // line buffer shift, new pixel enters at the top end
    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int k = 0; k < shift_len - 1; k++) begin
                shift_reg[k] <= shift_reg[k + 1];
            end
            shift_reg[shift_len - 1] <= shift_in;
        end
    end

    // weighted sum held from filter into emit
    always_ff @(posedge clock) begin
        if (sum_load) begin
            sum_reg <= window_sum;
        end
    end

    // constant divide, then saturate
    assign quotient = sum_reg / acc_t'(kernel_norm);
    assign blur_din = (quotient > acc_t'(pixel_max)) ? pixel_t'(pixel_max) : pixel_t'(quotient);

endmodule

// ==== sync_fifo.sv ====
// first-word-fall-through pixel FIFO with registered full and empty, used at both ends of the blur top
`timescale 1ns/1ps

module sync_fifo
    import blur_pkg::*;
#(
    parameter int fifo_depth = 16
) (
    input  logic   clock,
    input  logic   reset,
    // write side
    input  logic   wr_en,
    input  pixel_t din,
    output logic   full,
    // read side, dout valid whenever empty is low
    input  logic   rd_en,
    output logic   empty,
    output pixel_t dout
);

    // depth is a power of two, so pointers wrap on their own
    localparam int addr_bits = $clog2(fifo_depth);

    pixel_t                mem [fifo_depth];
    logic [addr_bits-1:0]  wr_ptr;
    logic [addr_bits-1:0]  rd_ptr;
    // one extra bit so a full buffer can be counted
    logic [addr_bits:0]    count;
    logic [addr_bits:0]    count_next;
    logic                  do_write;
    logic                  do_read;

    // overflowing writes and underflowing reads are dropped
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // occupancy after this edge
    always_comb begin
        case ({do_write, do_read})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // pointers, count and flags
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // flags follow the new count, so they are clean registers
            empty <= (count_next == '0);
            full  <= (count_next == (addr_bits+1)'(fifo_depth));
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // head word falls through to the output
    assign dout = mem[rd_ptr];

endmodule
